/* design/winRatePkg.sv */
// ============================================================
// win rate package
// table constants and shared types for the showdown pipeline
// ============================================================
package winRatePkg;

    // table geometry
    localparam int NUM_PLAYERS   = 9;
    localparam int NUM_PUB_GIVEN = 3;
    localparam int DECK_SIZE     = 52;
    localparam int PAIR_COUNT    = 465;

    // lcm of 1..9 so every split is exact
    localparam int SHARE_TOTAL   = 2520;
    localparam int RATE_DIVISOR  = PAIR_COUNT * SHARE_TOTAL / 100;
    localparam int PIPE_LATENCY  = 468;

    typedef logic [3:0]             rankNum_t;
    typedef logic [1:0]             suit_t;
    typedef logic [5:0]             cardIdx_t;
    typedef logic [DECK_SIZE-1:0]   deckMask_t;
    typedef logic [6:0]             handScore_t;
    typedef logic [NUM_PLAYERS-1:0] playerMask_t;
    typedef logic [11:0]            share_t;
    typedef logic [20:0]            tally_t;
    typedef logic [6:0]             rate_t;

    // ascending strength, no flush categories
    typedef enum logic [2:0] {
        HC_HIGH       = 3'd0,
        HC_PAIR       = 3'd1,
        HC_TWO_PAIR   = 3'd2,
        HC_TRIPS      = 3'd3,
        HC_STRAIGHT   = 3'd4,
        HC_FULL_HOUSE = 3'd5,
        HC_QUADS      = 3'd6
    } handCat_t;

    typedef enum logic {
        EN_IDLE = 1'b0,
        EN_WALK = 1'b1
    } enumState_t;

endpackage

/* design/handRanker.sv */
// ============================================================
// hand ranker
// scores seven ranks as category above defining group rank
// ============================================================
`timescale 1ns/1ps

module handRanker import winRatePkg::*; (
    input  rankNum_t [6:0] sevenNum,
    output handScore_t     score
);

    logic [2:0] rankCnt [16];
    // bit 1 mirrors the ace for the wheel
    logic [14:1] present;
    rankNum_t    quadRank;
    rankNum_t    tripRank;
    rankNum_t    pairHi;
    rankNum_t    highRank;
    rankNum_t    straightTop;
    logic [2:0]  tripCnt;
    logic [2:0]  pairCnt;
    logic        fullHouse;
    handCat_t    cat;
    rankNum_t    groupRank;

    // per rank counts
    always_comb begin
        for (int r = 0; r < 16; r++) begin
            rankCnt[r] = '0;
        end
        for (int c = 0; c < 7; c++) begin
            rankCnt[sevenNum[c]] = rankCnt[sevenNum[c]] + 3'd1;
        end
    end

    always_comb begin
        present     = '0;
        quadRank    = '0;
        tripRank    = '0;
        pairHi      = '0;
        highRank    = '0;
        straightTop = '0;
        tripCnt     = '0;
        pairCnt     = '0;
        // ascending scan keeps the highest group of each size
        for (int r = 2; r <= 14; r++) begin
            present[r] = (rankCnt[r] != 3'd0);
            if (rankCnt[r] != 3'd0) highRank = rankNum_t'(r);
            if (rankCnt[r] == 3'd4) quadRank = rankNum_t'(r);
            if (rankCnt[r] == 3'd3) begin
                tripCnt  = tripCnt + 3'd1;
                tripRank = rankNum_t'(r);
            end
            if (rankCnt[r] == 3'd2) begin
                pairCnt = pairCnt + 3'd1;
                pairHi  = rankNum_t'(r);
            end
        end
        present[1] = present[14];
        for (int top = 5; top <= 14; top++) begin
            if (&present[top -: 5]) straightTop = rankNum_t'(top);
        end
    end

    // a second trips supplies the pair of a full house
    assign fullHouse = (tripCnt >= 3'd2) || (tripCnt != 3'd0 && pairCnt != 3'd0);

    always_comb begin
        if (quadRank != '0) begin
            cat       = HC_QUADS;
            groupRank = quadRank;
        end else if (fullHouse) begin
            cat       = HC_FULL_HOUSE;
            groupRank = tripRank;
        end else if (straightTop != '0) begin
            cat       = HC_STRAIGHT;
            groupRank = straightTop;
        end else if (tripCnt != 3'd0) begin
            cat       = HC_TRIPS;
            groupRank = tripRank;
        end else if (pairCnt >= 3'd2) begin
            cat       = HC_TWO_PAIR;
            groupRank = pairHi;
        end else if (pairCnt == 3'd1) begin
            cat       = HC_PAIR;
            groupRank = pairHi;
        end else begin
            cat       = HC_HIGH;
            groupRank = highRank;
        end
    end

    assign score = {cat, groupRank};

endmodule

/* design/deckEnumerator.sv */
// ============================================================
// deck enumerator
// masks out the 21 known cards and walks every unseen pair
// ============================================================
`timescale 1ns/1ps

module deckEnumerator import winRatePkg::*; (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid,
    input  rankNum_t [2*NUM_PLAYERS-1:0]   holeNum,
    input  suit_t    [2*NUM_PLAYERS-1:0]   holeSuit,
    input  rankNum_t [NUM_PUB_GIVEN-1:0]   pubNum,
    input  suit_t    [NUM_PUB_GIVEN-1:0]   pubSuit,
    output logic                           pairValid,
    output logic                           pairLast,
    output rankNum_t                       turnNum,
    output rankNum_t                       riverNum
);

    enumState_t state;
    deckMask_t  initMask;
    // candidates for the first card, lowest bit is the current one
    deckMask_t  firstRem;
    // candidates for the second card, all above the first
    deckMask_t  secondRem;
    deckMask_t  secondNext;
    deckMask_t  firstNext;
    deckMask_t  restartSecond;

    function automatic cardIdx_t cardIndex(suit_t s, rankNum_t n);
        cardIdx_t base;
        base = cardIdx_t'(s) * 6'd13;
        return base + cardIdx_t'(n) - 6'd2;
    endfunction

    // next set bit search from the bottom of the mask
    function automatic cardIdx_t lowestIdx(deckMask_t m);
        cardIdx_t idx;
        idx = '0;
        for (int i = DECK_SIZE - 1; i >= 0; i--) begin
            if (m[i]) idx = cardIdx_t'(i);
        end
        return idx;
    endfunction

    function automatic rankNum_t rankOf(cardIdx_t idx);
        return rankNum_t'(idx % 13 + 2);
    endfunction

    always_comb begin
        initMask = '1;
        for (int i = 0; i < 2 * NUM_PLAYERS; i++) begin
            initMask[cardIndex(holeSuit[i], holeNum[i])] = 1'b0;
        end
        for (int i = 0; i < NUM_PUB_GIVEN; i++) begin
            initMask[cardIndex(pubSuit[i], pubNum[i])] = 1'b0;
        end
    end

    assign secondNext    = secondRem & (secondRem - 1'b1);
    assign firstNext     = firstRem & (firstRem - 1'b1);
    assign restartSecond = firstNext & (firstNext - 1'b1);

    // two highest unseen cards reached
    assign pairValid = (state == EN_WALK);
    assign pairLast  = pairValid && (secondNext == '0) && (restartSecond == '0);
    assign turnNum   = rankOf(lowestIdx(firstRem));
    assign riverNum  = rankOf(lowestIdx(secondRem));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= EN_IDLE;
        end else if (state == EN_IDLE && in_valid) begin
            state <= EN_WALK;
        end else if (pairLast) begin
            state <= EN_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (state == EN_IDLE && in_valid) begin
            firstRem  <= initMask;
            secondRem <= initMask & (initMask - 1'b1);
        end else if (state == EN_WALK) begin
            if (secondNext != '0) begin
                secondRem <= secondNext;
            end else begin
                // advance the first card, restart the second above it
                firstRem  <= firstNext;
                secondRem <= restartSecond;
            end
        end
    end

endmodule

/* design/showdownJudge.sv */
// ============================================================
// showdown judge
// ranks all nine hands per board, registers the winner mask
// ============================================================
`timescale 1ns/1ps

module showdownJudge import winRatePkg::*; (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           pairValid,
    input  logic                           pairLast,
    input  rankNum_t [2*NUM_PLAYERS-1:0]   holeNum,
    input  rankNum_t [NUM_PUB_GIVEN-1:0]   pubNum,
    input  rankNum_t                       turnNum,
    input  rankNum_t                       riverNum,
    output logic                           winValid,
    output logic                           winLast,
    output playerMask_t                    winnerMask
);

    handScore_t  scores [NUM_PLAYERS];
    handScore_t  bestScore;
    playerMask_t maskNext;

    for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_player
        rankNum_t [6:0] seven;

        assign seven = {riverNum, turnNum, pubNum, holeNum[2*p+1], holeNum[2*p]};

        handRanker i_rank (
            .sevenNum (seven),
            .score    (scores[p])
        );
    end

    // ties share the top score, at least one bit always set
    always_comb begin
        bestScore = '0;
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            if (scores[p] > bestScore) bestScore = scores[p];
        end
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            maskNext[p] = (scores[p] == bestScore);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            winValid <= 1'b0;
            winLast  <= 1'b0;
        end else begin
            winValid <= pairValid;
            winLast  <= pairValid & pairLast;
        end
    end

    always_ff @(posedge clk) begin
        winnerMask <= maskNext;
    end

endmodule

/* design/shareTally.sv */
// ============================================================
// share tally
// splits each board among winners and reports percentages
// ============================================================
`timescale 1ns/1ps

module shareTally import winRatePkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     winValid,
    input  logic                     winLast,
    input  playerMask_t              winnerMask,
    output logic                     out_valid,
    output rate_t [NUM_PLAYERS-1:0]  winRateOut
);

    logic [3:0] winCount;
    share_t     share;
    tally_t     tally [NUM_PLAYERS];
    // tallies are final this cycle
    logic       flushPend;

    always_comb begin
        winCount = '0;
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            winCount = winCount + 4'(winnerMask[p]);
        end
    end

    always_comb begin
        case (winCount)
            4'd1:    share = share_t'(SHARE_TOTAL / 1);
            4'd2:    share = share_t'(SHARE_TOTAL / 2);
            4'd3:    share = share_t'(SHARE_TOTAL / 3);
            4'd4:    share = share_t'(SHARE_TOTAL / 4);
            4'd5:    share = share_t'(SHARE_TOTAL / 5);
            4'd6:    share = share_t'(SHARE_TOTAL / 6);
            4'd7:    share = share_t'(SHARE_TOTAL / 7);
            4'd8:    share = share_t'(SHARE_TOTAL / 8);
            4'd9:    share = share_t'(SHARE_TOTAL / 9);
            default: share = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flushPend <= 1'b0;
            for (int p = 0; p < NUM_PLAYERS; p++) tally[p] <= '0;
        end else begin
            flushPend <= winValid & winLast;
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                // next run's first board comes two cycles later
                if (flushPend) begin
                    tally[p] <= '0;
                end else if (winValid && winnerMask[p]) begin
                    tally[p] <= tally[p] + tally_t'(share);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            winRateOut <= '0;
        end else begin
            out_valid <= flushPend;
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                winRateOut[p] <= flushPend ? rate_t'(tally[p] / RATE_DIVISOR) : '0;
            end
        end
    end

endmodule

/* design/winRate.sv */
// ============================================================
// win rate top
// enumerator, showdown judge and share tally in a pipeline
// ============================================================
`timescale 1ns/1ps

module winRate import winRatePkg::*; (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid,
    input  rankNum_t [2*NUM_PLAYERS-1:0]   holeNum,
    input  suit_t    [2*NUM_PLAYERS-1:0]   holeSuit,
    input  rankNum_t [NUM_PUB_GIVEN-1:0]   pubNum,
    input  suit_t    [NUM_PUB_GIVEN-1:0]   pubSuit,
    output logic                           out_valid,
    output rate_t    [NUM_PLAYERS-1:0]     winRateOut
);

    logic        pairValid;
    logic        pairLast;
    rankNum_t    turnNum;
    rankNum_t    riverNum;
    logic        winValid;
    logic        winLast;
    playerMask_t winnerMask;

    deckEnumerator i_enumerator (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .holeNum   (holeNum),
        .holeSuit  (holeSuit),
        .pubNum    (pubNum),
        .pubSuit   (pubSuit),
        .pairValid (pairValid),
        .pairLast  (pairLast),
        .turnNum   (turnNum),
        .riverNum  (riverNum)
    );

    showdownJudge i_judge (
        .clk        (clk),
        .rst_n      (rst_n),
        .pairValid  (pairValid),
        .pairLast   (pairLast),
        .holeNum    (holeNum),
        .pubNum     (pubNum),
        .turnNum    (turnNum),
        .riverNum   (riverNum),
        .winValid   (winValid),
        .winLast    (winLast),
        .winnerMask (winnerMask)
    );

    shareTally i_tally (
        .clk        (clk),
        .rst_n      (rst_n),
        .winValid   (winValid),
        .winLast    (winLast),
        .winnerMask (winnerMask),
        .out_valid  (out_valid),
        .winRateOut (winRateOut)
    );

endmodule

/* testbench/winRate_asserts.sv */
// ============================================================
// win rate checker
// concurrent assertions on the result strobe and the rates
// ============================================================
`timescale 1ns/1ps

module winRate_asserts import winRatePkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  logic                     out_valid,
    input  rate_t [NUM_PLAYERS-1:0]  winRateOut
);

    int                      failCount = 0;
    logic                    accepted;
    // pairs still to come in the running walk
    logic [9:0]              walkLeft;
    logic [10:0]             rateSum;
    rate_t [NUM_PLAYERS-1:0] acesExpect;

    // a start only counts once the previous walk is over
    assign accepted = in_valid && (walkLeft == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            walkLeft <= '0;
        end else if (accepted) begin
            walkLeft <= 10'(PAIR_COUNT);
        end else if (walkLeft != '0) begin
            walkLeft <= walkLeft - 10'd1;
        end
    end

    always_comb begin
        rateSum = '0;
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            rateSum = rateSum + 11'(winRateOut[p]);
        end
        acesExpect    = '0;
        acesExpect[4] = 7'd100;
    end

    a_resetLow: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else begin
            failCount++;
            $error("[FAIL] out_valid=%h in reset, expected 0", $sampled(out_valid));
        end

    // exactly one result per accepted start, no stray pulses
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(accepted, PIPE_LATENCY))
        else begin
            failCount++;
            $error("[FAIL] out_valid=%h expected %h", $sampled(out_valid),
                   !$sampled(out_valid));
        end

    a_pulseWidth: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid)
        else begin
            failCount++;
            $error("out_valid stayed high for more than one cycle");
        end

    a_idleZero: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> winRateOut == '0)
        else begin
            failCount++;
            $error("[FAIL] winRateOut=%h expected 0", $sampled(winRateOut));
        end

    // truncation loses under one point per player
    a_rateSum: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (rateSum >= 11'd91 && rateSum <= 11'd100))
        else begin
            failCount++;
            $error("[FAIL] rateSum=%h expected 5b to 64", $sampled(rateSum));
        end

    a_mirror: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && tbWinRate.mirrorDeal) |-> winRateOut[0] == winRateOut[1])
        else begin
            failCount++;
            $error("[FAIL] winRateOut[0]=%h winRateOut[1]=%h expected equal",
                   $sampled(winRateOut[0]), $sampled(winRateOut[1]));
        end

    a_aces: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && tbWinRate.acesDeal) |-> winRateOut == acesExpect)
        else begin
            failCount++;
            $error("[FAIL] winRateOut=%h expected %h", $sampled(winRateOut), acesExpect);
        end

endmodule

/* testbench/tbWinRate.sv */
// ============================================================
// win rate testbench
// random, mirrored and all-aces deals plus a mid-walk start
// ============================================================
`timescale 1ns/1ps

module tbWinRate import winRatePkg::*; ();

    localparam int NUM_RUNS        = 8;
    localparam int WATCHDOG_CYCLES = 10 * PIPE_LATENCY * NUM_RUNS;
    localparam int NUM_SLOTS       = 2 * NUM_PLAYERS + NUM_PUB_GIVEN;

    logic                         clk;
    logic                         rst_n;
    logic                         in_valid;
    rankNum_t [2*NUM_PLAYERS-1:0] holeNum;
    suit_t    [2*NUM_PLAYERS-1:0] holeSuit;
    rankNum_t [NUM_PUB_GIVEN-1:0] pubNum;
    suit_t    [NUM_PUB_GIVEN-1:0] pubSuit;
    logic                         out_valid;
    rate_t    [NUM_PLAYERS-1:0]   winRateOut;

    // scenario flags, read by the bound checker
    logic mirrorDeal;
    logic acesDeal;

    logic [31:0] lfsrState;
    // slots 0..17 are hole cards, 18..20 the public cards
    rankNum_t    slotNum    [NUM_SLOTS];
    suit_t       slotSuit   [NUM_SLOTS];
    logic        slotFilled [NUM_SLOTS];
    deckMask_t   usedCards;

    winRate i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .holeNum    (holeNum),
        .holeSuit   (holeSuit),
        .pubNum     (pubNum),
        .pubSuit    (pubSuit),
        .out_valid  (out_valid),
        .winRateOut (winRateOut)
    );

    bind winRate winRate_asserts i_asserts (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .out_valid  (out_valid),
        .winRateOut (winRateOut)
    );

    always #2 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic int deckPos(int suit, int rank);
        return suit * 13 + rank - 2;
    endfunction

    task automatic takeBits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[6:0], lfsrState[0]};
        end
    endtask

    task automatic clearDeal();
        for (int s = 0; s < NUM_SLOTS; s++) slotFilled[s] = 1'b0;
        usedCards = '0;
    endtask

    task automatic placeCard(input int slot, input int idx);
        slotSuit[slot]   = suit_t'(idx / 13);
        slotNum[slot]    = rankNum_t'(idx % 13 + 2);
        slotFilled[slot] = 1'b1;
        usedCards[idx]   = 1'b1;
    endtask

    task automatic drawRank(output int rank);
        logic [7:0] v;
        do begin
            takeBits(4, v);
        end while (v < 8'd2 || v > 8'd14);
        rank = int'(v);
    endtask

    task automatic fillOpenSlots();
        logic [7:0] draw;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (!slotFilled[s]) begin
                // reject positions past the deck and cards already dealt
                do begin
                    takeBits(6, draw);
                end while (draw >= 8'(DECK_SIZE) || usedCards[draw[5:0]]);
                placeCard(s, int'(draw));
            end
        end
    endtask

    task automatic driveCards();
        for (int i = 0; i < 2 * NUM_PLAYERS; i++) begin
            holeNum[i]  = slotNum[i];
            holeSuit[i] = slotSuit[i];
        end
        for (int i = 0; i < NUM_PUB_GIVEN; i++) begin
            pubNum[i]  = slotNum[2*NUM_PLAYERS+i];
            pubSuit[i] = slotSuit[2*NUM_PLAYERS+i];
        end
    endtask

    task automatic pulseInValid();
        @(posedge clk);
        #1 in_valid = 1'b1;
        @(posedge clk);
        #1 in_valid = 1'b0;
    endtask

    task automatic awaitResult();
        do begin
            @(negedge clk);
        end while (!out_valid);
        // checker samples the result on this edge, flags drop after it
        @(posedge clk);
        #1;
        mirrorDeal = 1'b0;
        acesDeal   = 1'b0;
    endtask

    task automatic runDeal();
        @(posedge clk);
        #1 driveCards();
        pulseInValid();
        awaitResult();
    endtask

    initial begin
        int rankA;
        int rankB;
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        holeNum    = '0;
        holeSuit   = '0;
        pubNum     = '0;
        pubSuit    = '0;
        mirrorDeal = 1'b0;
        acesDeal   = 1'b0;
        lfsrState  = 32'd97594;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;

        for (int r = 0; r < 5; r++) begin
            clearDeal();
            fillOpenSlots();
            runDeal();
        end

        // players 0 and 1 share ranks, all four suits distinct
        clearDeal();
        drawRank(rankA);
        drawRank(rankB);
        placeCard(0, deckPos(0, rankA));
        placeCard(1, deckPos(1, rankB));
        placeCard(2, deckPos(2, rankA));
        placeCard(3, deckPos(3, rankB));
        fillOpenSlots();
        mirrorDeal = 1'b1;
        runDeal();

        // three aces on the board, the fourth with player 4
        clearDeal();
        for (int i = 0; i < NUM_PUB_GIVEN; i++) placeCard(2 * NUM_PLAYERS + i, deckPos(i, 14));
        placeCard(8, deckPos(3, 14));
        fillOpenSlots();
        acesDeal = 1'b1;
        runDeal();

        // a second start in mid-walk must be dropped
        clearDeal();
        fillOpenSlots();
        @(posedge clk);
        #1 driveCards();
        pulseInValid();
        repeat (200) @(posedge clk);
        #1 in_valid = 1'b1;
        @(posedge clk);
        #1 in_valid = 1'b0;
        awaitResult();
        repeat (PIPE_LATENCY + 8) @(posedge clk);

        repeat (4) @(posedge clk);
        #1;
        if (i_dut.i_asserts.failCount == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1, "bound checker reported failures");
        end
    end

    initial begin
        wait (i_dut.i_asserts.failCount != 0);
        #1;
        $display("ERRORS FOUND");
        $fatal(1, "assertion failure in the bound checker");
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired before all runs completed");
    end

endmodule

/* verilog.f */
design/winRatePkg.sv
design/handRanker.sv
design/deckEnumerator.sv
design/showdownJudge.sv
design/shareTally.sv
design/winRate.sv
testbench/winRate_asserts.sv
testbench/tbWinRate.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the win rate testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tbWinRate \
    --Mdir obj_dir -o simWinRate

# keep running after an assertion error so the testbench can report it
./obj_dir/simWinRate +verilator+error+limit+1000
